// ==== rtl/muldiv_macros.svh ====
// Operand width and division step count defines for the muldiv coprocessor
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// ------------------------------------------------------------
// Datapath sizing
// ------------------------------------------------------------

// Operand and result width in bits
`define MULDIV_XLEN 32

// ------------------------------------------------------------
// Division pacing
// ------------------------------------------------------------

`define MULDIV_DIV_STEPS 32  // One restoring step per quotient bit

`endif

// ==== rtl/muldiv_op_pkg.sv ====
// Operation opcodes and request/response bundles of the muldiv coprocessor
`include "muldiv_macros.svh"

package muldiv_op_pkg;

    // ------------------------------------------------------------
    // Opcodes, numbered like RV32M funct3
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,  // Low word, any signedness
        OP_MULH   = 3'd1,  // High word, signed x signed
        OP_MULHSU = 3'd2,  // High word, signed x unsigned
        OP_MULHU  = 3'd3,  // High word, unsigned x unsigned
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

    // ------------------------------------------------------------
    // Handshake payloads
    // ------------------------------------------------------------
    typedef struct packed {
        muldiv_op_e              op;
        logic [`MULDIV_XLEN-1:0] a;  // rs1 operand, dividend
        logic [`MULDIV_XLEN-1:0] b;  // rs2 operand, divisor
    } muldiv_req_t;

    typedef struct packed {
        logic [`MULDIV_XLEN-1:0] result;
    } muldiv_resp_t;

endpackage

// ==== rtl/muldiv_ctrl_pkg.sv ====
// Sequencer states, datapath strobes and step count type of the muldiv coprocessor
`include "muldiv_macros.svh"

package muldiv_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,       // Waiting for a request
        MUL_EXEC,   // Product being formed
        DIV_CHECK,  // Divisor zero test
        DIV_EXEC,   // Restoring steps
        DONE        // Result held for the requester
    } seq_state_e;

    // One strobe per datapath action, all from the sequencer
    typedef struct packed {
        logic mul_load;
        logic mul_exec;
        logic div_load;
        logic div_prep;
        logic div_zero;
        logic div_step;
        logic hold;
    } dp_ctrl_t;

    typedef logic [$clog2(`MULDIV_DIV_STEPS)-1:0] step_cnt_t;

endpackage

// ==== rtl/step_counter.sv ====
// Down-counter pacing the restoring division steps
`timescale 1ns/100ps
`include "muldiv_macros.svh"

module step_counter (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start_i,
    input  logic step_i,
    output logic last_o
);
    import muldiv_ctrl_pkg::*;

    step_cnt_t cnt;

    // Counts STEPS-1 down to zero, one division step per count
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt <= '0;
        end else if (start_i) begin
            cnt <= step_cnt_t'(`MULDIV_DIV_STEPS - 1);
        end else if (step_i && (cnt != '0)) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign last_o = (cnt == '0);  // Final step in progress

endmodule

// ==== rtl/mul_datapath.sv ====
// Multiplier datapath with operand extension, product register and word select
`timescale 1ns/100ps
`include "muldiv_macros.svh"

module mul_datapath (
    input  logic                        clk_i,
    input  muldiv_op_pkg::muldiv_req_t  req_i,
    input  muldiv_ctrl_pkg::dp_ctrl_t   ctrl_i,
    output muldiv_op_pkg::muldiv_resp_t resp_o
);
    import muldiv_op_pkg::*;

    localparam int W = `MULDIV_XLEN;

    logic                  mul_sel;    // Held result belongs to this datapath
    logic                  is_high;
    logic signed [W:0]     mcand;      // One extra bit carries the sign
    logic signed [W:0]     mplier;
    logic signed [2*W+1:0] full_prod;
    logic [2*W-1:0]        product;
    logic                  a_signed;
    logic                  b_signed;

    assign a_signed  = req_i.op inside {OP_MULH, OP_MULHSU};
    assign b_signed  = (req_i.op == OP_MULH);
    assign full_prod = mcand * mplier;

    always_ff @(posedge clk_i) begin
        if (ctrl_i.mul_load) begin
            mcand   <= {a_signed && req_i.a[W-1], req_i.a};
            mplier  <= {b_signed && req_i.b[W-1], req_i.b};
            is_high <= (req_i.op != OP_MUL);
        end
        if (ctrl_i.mul_exec) begin
            product <= full_prod[2*W-1:0];
        end
        if (ctrl_i.mul_load) begin
            mul_sel <= 1'b1;
        end else if (ctrl_i.div_load) begin
            mul_sel <= 1'b0;
        end
    end

    always_comb begin
        resp_o = '0;
        if (ctrl_i.hold && mul_sel) begin
            resp_o.result = is_high ? product[2*W-1:W] : product[W-1:0];
        end
    end

endmodule

// ==== rtl/div_datapath.sv ====
// Restoring divider datapath with sign handling and RISC-V result fix-up
`timescale 1ns/100ps
`include "muldiv_macros.svh"

module div_datapath (
    input  logic                        clk_i,
    input  muldiv_op_pkg::muldiv_req_t  req_i,
    input  muldiv_ctrl_pkg::dp_ctrl_t   ctrl_i,
    output logic                        divisor_zero_o,
    output muldiv_op_pkg::muldiv_resp_t resp_o
);
    import muldiv_op_pkg::*;

    localparam int W = `MULDIV_XLEN;

    logic         div_sel;    // Held result belongs to this datapath
    logic         is_rem;
    logic         dvd_neg;
    logic         dvs_neg;
    logic         quo_neg;
    logic         rem_neg;
    logic [W-1:0] divisor;
    logic [W-1:0] remainder;
    logic [W-1:0] quotient;

    logic         is_signed;
    logic [W+1:0] diff;       // Trial subtraction, top bit is the borrow
    logic         q_bit;
    logic [W-1:0] rem_out;
    logic [W-1:0] quo_out;

    assign is_signed      = (req_i.op == OP_DIV) || (req_i.op == OP_REM);
    assign diff           = {1'b0, remainder, quotient[W-1]} - {2'b00, divisor};
    assign q_bit          = ~diff[W+1];
    assign divisor_zero_o = (divisor == '0);

    // ------------------------------------------------------------
    // Operand capture, magnitude prep and shift-subtract steps
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (ctrl_i.div_load) begin
            is_rem    <= (req_i.op == OP_REM) || (req_i.op == OP_REMU);
            dvd_neg   <= is_signed && req_i.a[W-1];
            dvs_neg   <= is_signed && req_i.b[W-1];
            quo_neg   <= is_signed && (req_i.a[W-1] ^ req_i.b[W-1]);
            rem_neg   <= is_signed && req_i.a[W-1];  // Remainder follows dividend
            divisor   <= req_i.b;
            remainder <= req_i.a;  // Dividend parked here until prep
            quotient  <= '0;
        end else if (ctrl_i.div_zero) begin
            // Quotient all ones, remainder keeps the raw dividend
            quotient <= '1;
            quo_neg  <= 1'b0;
            rem_neg  <= 1'b0;
        end else if (ctrl_i.div_prep) begin
            divisor   <= dvs_neg ? -divisor : divisor;
            remainder <= '0;
            quotient  <= dvd_neg ? -remainder : remainder;
        end else if (ctrl_i.div_step) begin
            if (q_bit) begin
                remainder <= diff[W-1:0];
            end else begin
                remainder <= {remainder[W-2:0], quotient[W-1]};
            end
            quotient <= {quotient[W-2:0], q_bit};  // Dividend shifts out, quotient in
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.div_load) begin
            div_sel <= 1'b1;
        end else if (ctrl_i.mul_load) begin
            div_sel <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Result fix-up
    // ------------------------------------------------------------
    assign rem_out = rem_neg ? -remainder : remainder;
    assign quo_out = quo_neg ? -quotient : quotient;

    always_comb begin
        resp_o = '0;
        if (ctrl_i.hold && div_sel) begin
            resp_o.result = is_rem ? rem_out : quo_out;
        end
    end

endmodule

// ==== rtl/muldiv_seq.sv ====
// Sequencer FSM for the req/ack handshake and multiply/divide stepping
`timescale 1ns/100ps

module muldiv_seq (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      req_i,
    input  muldiv_op_pkg::muldiv_op_e op_i,
    input  logic                      divisor_zero_i,
    input  logic                      last_i,
    output muldiv_ctrl_pkg::dp_ctrl_t ctrl_o,
    output logic                      cnt_start_o,
    output logic                      cnt_step_o,
    output logic                      ack_o
);
    import muldiv_op_pkg::*;
    import muldiv_ctrl_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;
    logic       is_mul_op;
    logic       accept;

    assign is_mul_op = op_i inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    assign accept    = req_i && !ack_o;  // Previous handshake fully closed

    // ------------------------------------------------------------
    // Next state and strobes
    // ------------------------------------------------------------
    always_comb begin
        state_nxt   = state;
        ctrl_o      = '0;
        cnt_start_o = 1'b0;
        cnt_step_o  = 1'b0;
        case (state)
            IDLE: begin
                if (accept) begin
                    if (is_mul_op) begin
                        ctrl_o.mul_load = 1'b1;
                        state_nxt       = MUL_EXEC;
                    end else begin
                        ctrl_o.div_load = 1'b1;
                        state_nxt       = DIV_CHECK;
                    end
                end
            end
            MUL_EXEC: begin
                ctrl_o.mul_exec = 1'b1;
                state_nxt       = DONE;
            end
            DIV_CHECK: begin
                if (divisor_zero_i) begin
                    ctrl_o.div_zero = 1'b1;  // Skip the steps entirely
                    state_nxt       = DONE;
                end else begin
                    ctrl_o.div_prep = 1'b1;
                    cnt_start_o     = 1'b1;
                    state_nxt       = DIV_EXEC;
                end
            end
            DIV_EXEC: begin
                ctrl_o.div_step = 1'b1;
                cnt_step_o      = 1'b1;
                if (last_i) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                if (!req_i) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
        // Result stays up through the ack tail after req drops
        ctrl_o.hold = (state == DONE) || ack_o;
    end

    // ------------------------------------------------------------
    // State and ack registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE;
            ack_o <= 1'b0;
        end else begin
            state <= state_nxt;
            ack_o <= (state == DONE);  // Trails DONE by one cycle
        end
    end

endmodule

// ==== rtl/muldiv_unit.sv ====
// Top of the muldiv coprocessor: sequencer, step counter and both datapaths
`timescale 1ns/100ps

module muldiv_unit (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        req_i,
    input  muldiv_op_pkg::muldiv_req_t  op_req_i,
    output logic                        ack_o,
    output muldiv_op_pkg::muldiv_resp_t resp_o
);
    import muldiv_op_pkg::*;
    import muldiv_ctrl_pkg::*;

    dp_ctrl_t     dp_ctrl;
    logic         cnt_start;
    logic         cnt_step;
    logic         cnt_last;
    logic         divisor_zero;
    muldiv_resp_t mul_resp;
    muldiv_resp_t div_resp;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    muldiv_seq muldiv_seq_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_i          (req_i),
        .op_i           (op_req_i.op),
        .divisor_zero_i (divisor_zero),
        .last_i         (cnt_last),
        .ctrl_o         (dp_ctrl),
        .cnt_start_o    (cnt_start),
        .cnt_step_o     (cnt_step),
        .ack_o          (ack_o)
    );

    step_counter step_counter_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (cnt_start),
        .step_i  (cnt_step),
        .last_o  (cnt_last)
    );

    // ------------------------------------------------------------
    // Datapaths
    // ------------------------------------------------------------
    div_datapath div_datapath_i (
        .clk_i          (clk_i),
        .req_i          (op_req_i),
        .ctrl_i         (dp_ctrl),
        .divisor_zero_o (divisor_zero),
        .resp_o         (div_resp)
    );

    mul_datapath mul_datapath_i (
        .clk_i  (clk_i),
        .req_i  (op_req_i),
        .ctrl_i (dp_ctrl),
        .resp_o (mul_resp)
    );

    // Idle datapath drives zeros, so a plain OR merges them
    assign resp_o = mul_resp | div_resp;

endmodule

// ==== testbench/muldiv_checker.sv ====
// Reference model, response comparison and per-test report lines for the muldiv coprocessor
`timescale 1ns/100ps
`include "muldiv_macros.svh"

module muldiv_checker (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        req_i,
    input  muldiv_op_pkg::muldiv_req_t  op_req_i,
    input  logic                        ack_i,
    input  muldiv_op_pkg::muldiv_resp_t resp_i,
    output int                          tests_o,
    output int                          failed_o,
    output int                          errors_o
);
    import muldiv_op_pkg::*;

    localparam int W           = `MULDIV_XLEN;
    localparam int SHORT_LAT   = 2;                        // Multiply and divide by zero
    localparam int DIV_LAT     = `MULDIV_DIV_STEPS + 2;

    typedef enum logic [1:0] {WATCH_IDLE, WATCH_RUN, WATCH_ACKED} watch_e;

    watch_e       phase = WATCH_IDLE;
    string        cur_name = "reset";
    int           reset_edges;
    int           test_errs;
    int           cycles;
    int           exp_lat;
    int           drop_cnt;
    logic         prev_req;
    logic [W-1:0] expected;
    logic [W-1:0] held;

    // ------------------------------------------------------------
    // Reference model, 64-bit arithmetic with RISC-V corner rules
    // ------------------------------------------------------------
    function automatic logic [W-1:0] model_result(input muldiv_req_t r);
        longint         sa;
        longint         sb;
        longint         sq;
        logic [2*W-1:0] ua;
        logic [2*W-1:0] ub;
        logic [2*W-1:0] prod;
        sa = longint'($signed(r.a));
        sb = longint'($signed(r.b));
        ua = {{W{1'b0}}, r.a};
        ub = {{W{1'b0}}, r.b};
        case (r.op)
            OP_MUL:    prod = ua * ub;
            OP_MULH:   prod = sa * sb;
            OP_MULHSU: prod = sa * ub;  // Low 64 bits agree with the signed product
            OP_MULHU:  prod = ua * ub;
            OP_DIV:    sq = (r.b == '0) ? -1 : sa / sb;  // MIN / -1 wraps to MIN on its own
            OP_DIVU:   prod = (r.b == '0) ? '1 : ua / ub;
            OP_REM:    sq = (r.b == '0) ? sa : sa % sb;
            default:   prod = (r.b == '0) ? ua : ua % ub;
        endcase
        if (r.op == OP_MUL || r.op == OP_DIVU || r.op == OP_REMU) begin
            return prod[W-1:0];
        end else if (r.op == OP_DIV || r.op == OP_REM) begin
            return sq[W-1:0];
        end
        return prod[2*W-1:W];
    endfunction

    task automatic report_plain(input string msg);
        $display("%s: %s", cur_name, msg);
        test_errs = test_errs + 1;
    endtask

    task automatic check_value(input string what, input logic [W-1:0] exp_v,
                               input logic [W-1:0] act_v, input bit as_hex);
        if (exp_v !== act_v) begin
            if (as_hex) begin
                $display("** Error %s %s: expected %h, actual %h", cur_name, what, exp_v, act_v);
            end else begin
                $display("** Error %s %s: expected %0d, actual %0d", cur_name, what, exp_v, act_v);
            end
            test_errs = test_errs + 1;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("%s passed", cur_name);
        end else begin
            $display("%s failed with %0d errors", cur_name, test_errs);
            failed_o = failed_o + 1;
        end
        errors_o  = errors_o + test_errs;
        tests_o   = tests_o + 1;
        test_errs = 0;
        cur_name  = "idle";
    endtask

    // ------------------------------------------------------------
    // Port watcher, sampled on the rising edge
    // ------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_i) begin
            if (reset_edges > 0 && ack_i !== 1'b0) begin
                report_plain("ack_o is not low during reset");
            end
            reset_edges = reset_edges + 1;
            phase       = WATCH_IDLE;
            cur_name    = "reset";
        end else begin
            if (reset_edges > 0) begin
                if (ack_i !== 1'b0) begin
                    report_plain("ack_o is not low after reset");
                end
                finish_test();
                reset_edges = 0;
            end
            if (phase == WATCH_RUN) begin
                cycles = cycles + 1;
                if (ack_i) begin
                    if (!prev_req) begin
                        report_plain("ack_o rose while req_i was low");
                    end
                    // Ack seen here was set one edge earlier
                    check_value("latency", exp_lat, cycles - 1, 1'b0);
                    check_value("result", expected, resp_i.result, 1'b1);
                    held     = resp_i.result;
                    drop_cnt = -1;
                    phase    = WATCH_ACKED;
                end
            end
            if (phase == WATCH_ACKED) begin
                if (ack_i) begin
                    check_value("held result", held, resp_i.result, 1'b1);
                end
                if (drop_cnt >= 0) begin
                    drop_cnt = drop_cnt + 1;
                end else if (!req_i) begin
                    drop_cnt = 0;  // First edge that sees the release
                end
                if (!ack_i) begin
                    if (drop_cnt < 0) begin
                        report_plain("ack_o fell while req_i was still high");
                    end else begin
                        check_value("ack fall delay", 1, drop_cnt - 1, 1'b0);
                    end
                    finish_test();
                    phase = WATCH_IDLE;
                end
            end
            if (phase == WATCH_IDLE) begin
                if (ack_i) begin
                    report_plain("ack_o is high with no request in flight");
                end else if (req_i) begin
                    cur_name = $sformatf("test %0d %s", tests_o, op_req_i.op.name());
                    expected = model_result(op_req_i);
                    exp_lat  = (op_req_i.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU}
                                || op_req_i.b == '0) ? SHORT_LAT : DIV_LAT;
                    cycles   = 0;
                    phase    = WATCH_RUN;
                end
            end
        end
        prev_req = req_i;
    end

endmodule

// ==== testbench/muldiv_assert.sv ====
// Concurrent handshake assertions bound to the muldiv_unit top
`timescale 1ns/100ps

module muldiv_assert (
    input logic                        clk_i,
    input logic                        rst_i,
    input logic                        req_i,
    input logic                        ack_i,
    input muldiv_op_pkg::muldiv_resp_t resp_i,
    input muldiv_ctrl_pkg::seq_state_e state_i
);
    import muldiv_ctrl_pkg::*;

    // Ack only answers a live request
    ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack_o rose without req_i");

    resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i && $past(ack_i) |-> $stable(resp_i))
        else $error("resp_o changed while ack_o was high");

    // Release seen on one edge, ack gone after the next
    ack_release: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i && $fell(req_i) |-> ##2 !ack_i)
        else $error("ack_o did not fall one cycle after req_i fell");

    // Both datapaths quiet between operations, so the OR merge stays clean
    resp_idle_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_i == IDLE) && !ack_i |-> (resp_i == '0))
        else $error("resp_o not zero while the unit was idle");

endmodule

bind muldiv_unit muldiv_assert muldiv_assert_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (req_i),
    .ack_i   (ack_o),
    .resp_i  (resp_o),
    .state_i (muldiv_seq_i.state)
);

// ==== testbench/tb_muldiv.sv ====
// Testbench top: clock, reset, LCG stimulus, req/ack driver, watchdog and summary
`timescale 1ns/100ps
`include "muldiv_macros.svh"

module tb_muldiv;
    import muldiv_op_pkg::*;

    localparam int W            = `MULDIV_XLEN;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 200;
    localparam int NUM_DIRECTED = 4;
    localparam int TEST_CYCLES  = `MULDIV_DIV_STEPS + 2 + 3 + 4;  // Divide, linger, release
    localparam int WATCHDOG_NS  = 2 * NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
    localparam logic [W-1:0] MIN_INT = {1'b1, {(W-1){1'b0}}};

    logic         clk;
    logic         rst;
    logic         req;
    muldiv_req_t  op_req;
    logic         ack;
    muldiv_resp_t resp;
    logic [31:0]  rng_state;
    int           tests_done;
    int           tests_failed;
    int           error_count;

    muldiv_unit muldiv_unit_i (
        .clk_i    (clk),
        .rst_i    (rst),
        .req_i    (req),
        .op_req_i (op_req),
        .ack_o    (ack),
        .resp_o   (resp)
    );

    muldiv_checker muldiv_checker_i (
        .clk_i    (clk),
        .rst_i    (rst),
        .req_i    (req),
        .op_req_i (op_req),
        .ack_i    (ack),
        .resp_i   (resp),
        .tests_o  (tests_done),
        .failed_o (tests_failed),
        .errors_o (error_count)
    );

    // ------------------------------------------------------------
    // Random source and request driver
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng_state = lcg_next(rng_state);
        v         = rng_state;
    endtask

    task automatic draw_operand(output logic [W-1:0] v);
        logic [31:0] r;
        draw(r);
        if (r[31:29] == 3'd0) begin  // About one in eight is a corner value
            case (r[15:0] % 3)
                0:       v = '0;
                1:       v = '1;
                default: v = MIN_INT;
            endcase
        end else begin
            draw(v);
        end
    endtask

    task automatic run_op(input muldiv_op_e op, input logic [W-1:0] a, input logic [W-1:0] b);
        logic [31:0] r;
        @(negedge clk);
        op_req.op = op;
        op_req.a  = a;
        op_req.b  = b;
        req       = 1'b1;
        do @(negedge clk); while (!ack);
        draw(r);
        repeat (r[31:30]) @(negedge clk);  // Requester lingers 0 to 3 cycles
        req = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns with %0d of %0d tests finished",
                 $time, tests_done, NUM_TESTS + 1);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0]  r;
        logic [W-1:0] a;
        logic [W-1:0] b;
        muldiv_op_e   op;
        rst       = 1'b1;
        req       = 1'b0;
        op_req    = '0;
        rng_state = 32'heb9629fa;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Overflow and divide-by-zero corners first
        run_op(OP_DIV, MIN_INT, '1);
        run_op(OP_REM, MIN_INT, '1);
        run_op(OP_DIVU, 32'h1234_5678, '0);
        run_op(OP_REM, 32'h8765_4321, '0);

        for (int i = 0; i < NUM_TESTS - NUM_DIRECTED; i++) begin
            draw(r);
            op = muldiv_op_e'(r[31:29]);
            draw_operand(a);
            draw_operand(b);
            run_op(op, a, b);
        end

        wait (tests_done == NUM_TESTS + 1);  // Reset counts as a test
        $display("%0d tests, %0d failed, %0d errors", tests_done, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/muldiv_op_pkg.sv
rtl/muldiv_ctrl_pkg.sv
rtl/step_counter.sv
rtl/mul_datapath.sv
rtl/div_datapath.sv
rtl/muldiv_seq.sv
rtl/muldiv_unit.sv
testbench/muldiv_checker.sv
testbench/muldiv_assert.sv
testbench/tb_muldiv.sv

// ==== Bender.yml ====
package:
  name: muldiv

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/muldiv_op_pkg.sv
      - rtl/muldiv_ctrl_pkg.sv
      - rtl/step_counter.sv
      - rtl/mul_datapath.sv
      - rtl/div_datapath.sv
      - rtl/muldiv_seq.sv
      - rtl/muldiv_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/muldiv_checker.sv
      - testbench/muldiv_assert.sv
      - testbench/tb_muldiv.sv
